//--- source/i2c_types_pkg.sv
/*
  Vector types shared by the I2C master.
  Only 7-bit addressing is supported. delay_t is one bit wider than
  the prescale value so it can hold twice PRESCALE.
*/
`default_nettype none

package i2c_types_pkg;

  // width of the PRESCALE parameter
  localparam int PRESCALE_W = 16;

  // 7-bit target address
  typedef logic [6:0] i2c_addr_t;

  // one data byte on the bus
  typedef logic [7:0] i2c_byte_t;

  // bits left in an address or data phase, counts 8 down to 0
  typedef logic [3:0] bit_count_t;

  // phase delay counter, up to 2 * PRESCALE
  typedef logic [PRESCALE_W:0] delay_t;

endpackage

`default_nettype wire

//--- source/i2c_fsm_pkg.sv
/*
  State machine encodings for the I2C master.
  phy_op_t is a one-cycle request from the byte controller to the bit phy.
*/
`default_nettype none

package i2c_fsm_pkg;

  // byte-level command states
  typedef enum logic [3:0] {
    CTRL_IDLE,
    CTRL_ACTIVE_WRITE,
    CTRL_ACTIVE_READ,
    CTRL_START_WAIT,
    CTRL_START,
    CTRL_ADDRESS_1,
    CTRL_ADDRESS_2,
    CTRL_WRITE_1,
    CTRL_WRITE_2,
    CTRL_WRITE_3,
    CTRL_READ,
    CTRL_STOP
  } ctrl_state_t;

  // bit-level waveform states, idle and active are the only resting states
  typedef enum logic [3:0] {
    PHY_IDLE,
    PHY_ACTIVE,
    PHY_REPEATED_START_1,
    PHY_REPEATED_START_2,
    PHY_START_1,
    PHY_START_2,
    PHY_WRITE_BIT_1,
    PHY_WRITE_BIT_2,
    PHY_WRITE_BIT_3,
    PHY_READ_BIT_1,
    PHY_READ_BIT_2,
    PHY_READ_BIT_3,
    PHY_READ_BIT_4,
    PHY_STOP_1,
    PHY_STOP_2,
    PHY_STOP_3
  } phy_state_t;

  // request to the phy
  typedef enum logic [2:0] {
    OP_NONE,
    OP_START,
    OP_WRITE,
    OP_READ,
    OP_STOP
  } phy_op_t;

endpackage

`default_nettype wire

//--- source/i2c_bus_monitor.sv
/*
  Bus line synchronizer and start/stop detector.
  bus_active follows start and stop conditions from any master, two
  cycles after the SDA edge. Lines are taken as idle (high) out of reset.
*/
`default_nettype none

module i2c_bus_monitor (
  input  logic clk,
  input  logic rst,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_sync,
  output logic sda_sync,
  output logic bus_active
);

  logic scl_last;
  logic sda_last;
  logic start_cond;
  logic stop_cond;

  // sda edge while scl stays high on both samples
  assign start_cond = scl_sync & scl_last & sda_last & ~sda_sync;
  assign stop_cond = scl_sync & scl_last & ~sda_last & sda_sync;

  always_ff @(posedge clk) begin
    if (rst) begin
      scl_sync <= 1'b1;
      sda_sync <= 1'b1;
      scl_last <= 1'b1;
      sda_last <= 1'b1;
      bus_active <= 1'b0;
    end else begin
      // first stage feeds the phy, second stage for edges
      scl_sync <= scl_i;
      sda_sync <= sda_i;
      scl_last <= scl_sync;
      sda_last <= sda_sync;
      if (start_cond) begin
        bus_active <= 1'b1;
      end else if (stop_cond) begin
        bus_active <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/i2c_bit_phy.sv
/*
  I2C bit-level waveform generator, open-drain outputs (1 = released).
  Each phase lasts PRESCALE cycles, 2 * PRESCALE for SCL high on writes.
  A request is only taken while phy_busy is low.
*/
`default_nettype none

module i2c_bit_phy import i2c_types_pkg::*, i2c_fsm_pkg::*; #(
  parameter logic [PRESCALE_W-1:0] PRESCALE = 16'd4
) (
  input  logic    clk,
  input  logic    rst,
  input  phy_op_t phy_op,
  input  logic    phy_tx_bit,
  input  logic    scl_sync,
  input  logic    sda_sync,
  output logic    phy_busy,
  output logic    phy_rx_bit,
  output logic    scl_o,
  output logic    sda_o,
  output logic    bus_control
);

  localparam delay_t DELAY_1 = delay_t'(PRESCALE);
  localparam delay_t DELAY_2 = {PRESCALE, 1'b0};

  phy_state_t state;
  phy_state_t state_next;
  delay_t     delay;
  delay_t     delay_next;
  logic       delay_scl;
  logic       delay_scl_next;
  logic       delay_sda;
  logic       delay_sda_next;
  logic       scl_next;
  logic       sda_next;
  logic       bus_control_next;
  logic       rx_next;

  assign phy_busy = !(state == PHY_IDLE || state == PHY_ACTIVE);

  always_comb begin
    state_next = state;
    delay_next = delay;
    delay_scl_next = delay_scl;
    delay_sda_next = delay_sda;
    scl_next = scl_o;
    sda_next = sda_o;
    bus_control_next = bus_control;
    rx_next = phy_rx_bit;

    if (delay_scl) begin
      // released scl still low, target is stretching
      delay_scl_next = scl_o & ~scl_sync;
    end else if (delay_sda) begin
      // wait for released sda to read back high
      delay_sda_next = sda_o & ~sda_sync;
    end else if (delay != '0) begin
      delay_next = delay - delay_t'(1);
    end else begin
      case (state)
        PHY_IDLE: begin
          scl_next = 1'b1;
          sda_next = 1'b1;
          if (phy_op == OP_START) begin
            // sda falls with scl high
            sda_next = 1'b0;
            delay_next = DELAY_1;
            state_next = PHY_START_1;
          end
        end
        PHY_ACTIVE: begin
          // scl is low here, sda may change
          case (phy_op)
            OP_START: begin
              sda_next = 1'b1;
              delay_next = DELAY_1;
              state_next = PHY_REPEATED_START_1;
            end
            OP_WRITE: begin
              sda_next = phy_tx_bit;
              delay_next = DELAY_1;
              state_next = PHY_WRITE_BIT_1;
            end
            OP_READ: begin
              sda_next = 1'b1;
              delay_next = DELAY_1;
              state_next = PHY_READ_BIT_1;
            end
            OP_STOP: begin
              sda_next = 1'b0;
              delay_next = DELAY_1;
              state_next = PHY_STOP_1;
            end
            default: begin
              state_next = PHY_ACTIVE;
            end
          endcase
        end
        PHY_REPEATED_START_1: begin
          // raise scl with sda released
          scl_next = 1'b1;
          delay_scl_next = 1'b1;
          delay_sda_next = 1'b1;
          delay_next = DELAY_1;
          state_next = PHY_REPEATED_START_2;
        end
        PHY_REPEATED_START_2: begin
          sda_next = 1'b0;
          delay_next = DELAY_1;
          state_next = PHY_START_1;
        end
        PHY_START_1: begin
          scl_next = 1'b0;
          delay_next = DELAY_1;
          state_next = PHY_START_2;
        end
        PHY_START_2: begin
          bus_control_next = 1'b1;
          state_next = PHY_ACTIVE;
        end
        PHY_WRITE_BIT_1: begin
          // data set up, long scl high
          scl_next = 1'b1;
          delay_scl_next = 1'b1;
          delay_next = DELAY_2;
          state_next = PHY_WRITE_BIT_2;
        end
        PHY_WRITE_BIT_2: begin
          scl_next = 1'b0;
          delay_next = DELAY_1;
          state_next = PHY_WRITE_BIT_3;
        end
        PHY_WRITE_BIT_3: begin
          state_next = PHY_ACTIVE;
        end
        PHY_READ_BIT_1: begin
          scl_next = 1'b1;
          delay_scl_next = 1'b1;
          delay_next = DELAY_1;
          state_next = PHY_READ_BIT_2;
        end
        PHY_READ_BIT_2: begin
          // sample in the middle of scl high
          rx_next = sda_sync;
          delay_next = DELAY_1;
          state_next = PHY_READ_BIT_3;
        end
        PHY_READ_BIT_3: begin
          scl_next = 1'b0;
          delay_next = DELAY_1;
          state_next = PHY_READ_BIT_4;
        end
        PHY_READ_BIT_4: begin
          state_next = PHY_ACTIVE;
        end
        PHY_STOP_1: begin
          scl_next = 1'b1;
          delay_scl_next = 1'b1;
          delay_next = DELAY_1;
          state_next = PHY_STOP_2;
        end
        PHY_STOP_2: begin
          // sda rises with scl high
          sda_next = 1'b1;
          delay_sda_next = 1'b1;
          delay_next = DELAY_1;
          state_next = PHY_STOP_3;
        end
        PHY_STOP_3: begin
          bus_control_next = 1'b0;
          state_next = PHY_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= PHY_IDLE;
      delay <= '0;
      delay_scl <= 1'b0;
      delay_sda <= 1'b0;
      scl_o <= 1'b1;
      sda_o <= 1'b1;
      bus_control <= 1'b0;
    end else begin
      state <= state_next;
      delay <= delay_next;
      delay_scl <= delay_scl_next;
      delay_sda <= delay_sda_next;
      scl_o <= scl_next;
      sda_o <= sda_next;
      bus_control <= bus_control_next;
    end
  end

  always_ff @(posedge clk) begin
    phy_rx_bit <= rx_next;
  end

endmodule

`default_nettype wire

//--- source/i2c_byte_ctrl.sv
/*
  I2C byte-level command FSM with valid/ready host ports.
  A read is only acknowledged once the next command arrives, so SCL
  stays low while the host holds off. Only one byte per write command.
*/
`default_nettype none

module i2c_byte_ctrl import i2c_types_pkg::*, i2c_fsm_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  i2c_addr_t cmd_address,
  input  logic      cmd_start,
  input  logic      cmd_read,
  input  logic      cmd_write,
  input  logic      cmd_stop,
  input  logic      cmd_valid,
  output logic      cmd_ready,
  input  i2c_byte_t data_in,
  input  logic      data_in_valid,
  output logic      data_in_ready,
  output i2c_byte_t data_out,
  output logic      data_out_valid,
  input  logic      data_out_ready,
  input  logic      bus_active,
  input  logic      phy_busy,
  input  logic      phy_rx_bit,
  output phy_op_t   phy_op,
  output logic      phy_tx_bit,
  output logic      busy,
  output logic      missed_ack
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  i2c_addr_t   addr_reg;
  i2c_addr_t   addr_next;
  i2c_byte_t   data_reg;
  i2c_byte_t   data_next;
  i2c_byte_t   data_out_next;
  bit_count_t  bit_count;
  bit_count_t  bit_count_next;
  logic        mode_read;
  logic        mode_read_next;
  logic        mode_stop;
  logic        mode_stop_next;
  logic        cmd_ready_next;
  logic        data_in_ready_next;
  logic        data_out_valid_next;
  logic        missed_ack_next;
  logic        cmd_take;
  logic        is_xfer;
  logic        is_stop;
  logic        restart;

  assign cmd_take = cmd_valid & cmd_ready;
  // exactly one direction is a transfer, stop alone is a stop
  assign is_xfer = cmd_read ^ cmd_write;
  assign is_stop = cmd_stop & ~cmd_read & ~cmd_write;
  // new start needed on request, other target or other direction
  assign restart = cmd_start | (cmd_address != addr_reg) | (cmd_read != mode_read);

  always_comb begin
    state_next = state;
    phy_op = OP_NONE;
    phy_tx_bit = 1'b0;
    addr_next = addr_reg;
    data_next = data_reg;
    mode_read_next = mode_read;
    mode_stop_next = mode_stop;
    bit_count_next = bit_count;
    cmd_ready_next = 1'b0;
    data_in_ready_next = 1'b0;
    data_out_next = data_out;
    data_out_valid_next = data_out_valid & ~data_out_ready;
    missed_ack_next = 1'b0;

    // whole FSM waits on the phy
    if (!phy_busy) begin
      if (cmd_take && is_xfer) begin
        addr_next = cmd_address;
        mode_read_next = cmd_read;
        mode_stop_next = cmd_stop;
      end
      case (state)
        CTRL_IDLE: begin
          cmd_ready_next = 1'b1;
          if (cmd_take && is_xfer) begin
            cmd_ready_next = 1'b0;
            if (bus_active) begin
              // someone else owns the bus
              state_next = CTRL_START_WAIT;
            end else begin
              phy_op = OP_START;
              bit_count_next = 4'd8;
              state_next = CTRL_ADDRESS_1;
            end
          end
        end
        CTRL_ACTIVE_WRITE: begin
          cmd_ready_next = 1'b1;
          if (cmd_take && is_xfer) begin
            cmd_ready_next = 1'b0;
            if (restart) begin
              phy_op = OP_START;
              bit_count_next = 4'd8;
              state_next = CTRL_ADDRESS_1;
            end else begin
              // same target, keep writing
              data_in_ready_next = 1'b1;
              state_next = CTRL_WRITE_1;
            end
          end else if (cmd_take && is_stop) begin
            cmd_ready_next = 1'b0;
            phy_op = OP_STOP;
            state_next = CTRL_IDLE;
          end
        end
        CTRL_ACTIVE_READ: begin
          // no new command until the last byte is taken
          cmd_ready_next = ~data_out_valid;
          if (cmd_take && is_xfer) begin
            cmd_ready_next = 1'b0;
            phy_op = OP_WRITE;
            if (restart) begin
              // nack ends the read, then repeated start
              phy_tx_bit = 1'b1;
              state_next = CTRL_START;
            end else begin
              // ack and read on
              phy_tx_bit = 1'b0;
              bit_count_next = 4'd8;
              data_next = '0;
              state_next = CTRL_READ;
            end
          end else if (cmd_take && is_stop) begin
            cmd_ready_next = 1'b0;
            phy_op = OP_WRITE;
            phy_tx_bit = 1'b1;
            state_next = CTRL_STOP;
          end
        end
        CTRL_START_WAIT: begin
          if (!bus_active) begin
            phy_op = OP_START;
            bit_count_next = 4'd8;
            state_next = CTRL_ADDRESS_1;
          end
        end
        CTRL_START: begin
          phy_op = OP_START;
          bit_count_next = 4'd8;
          state_next = CTRL_ADDRESS_1;
        end
        CTRL_ADDRESS_1: begin
          // 7 address bits msb first, r/w bit, then ack slot
          bit_count_next = bit_count - 4'd1;
          if (bit_count > 4'd1) begin
            phy_op = OP_WRITE;
            phy_tx_bit = addr_reg[3'(bit_count - 4'd2)];
          end else if (bit_count > 4'd0) begin
            phy_op = OP_WRITE;
            phy_tx_bit = mode_read;
          end else begin
            phy_op = OP_READ;
            state_next = CTRL_ADDRESS_2;
          end
        end
        CTRL_ADDRESS_2: begin
          missed_ack_next = phy_rx_bit;
          if (mode_read) begin
            bit_count_next = 4'd8;
            data_next = '0;
            state_next = CTRL_READ;
          end else begin
            data_in_ready_next = 1'b1;
            state_next = CTRL_WRITE_1;
          end
        end
        CTRL_WRITE_1: begin
          // scl held low until the host supplies a byte
          data_in_ready_next = 1'b1;
          if (data_in_ready && data_in_valid) begin
            data_next = data_in;
            bit_count_next = 4'd8;
            data_in_ready_next = 1'b0;
            state_next = CTRL_WRITE_2;
          end
        end
        CTRL_WRITE_2: begin
          bit_count_next = bit_count - 4'd1;
          if (bit_count > 4'd0) begin
            phy_op = OP_WRITE;
            phy_tx_bit = data_reg[3'(bit_count - 4'd1)];
          end else begin
            phy_op = OP_READ;
            state_next = CTRL_WRITE_3;
          end
        end
        CTRL_WRITE_3: begin
          missed_ack_next = phy_rx_bit;
          if (mode_stop) begin
            phy_op = OP_STOP;
            state_next = CTRL_IDLE;
          end else begin
            state_next = CTRL_ACTIVE_WRITE;
          end
        end
        CTRL_READ: begin
          // first shift drops a stale bit, 8 real bits follow
          bit_count_next = bit_count - 4'd1;
          data_next = {data_reg[6:0], phy_rx_bit};
          if (bit_count > 4'd0) begin
            phy_op = OP_READ;
          end else begin
            data_out_next = data_next;
            data_out_valid_next = 1'b1;
            if (mode_stop) begin
              // nack the last byte before stop
              phy_op = OP_WRITE;
              phy_tx_bit = 1'b1;
              state_next = CTRL_STOP;
            end else begin
              state_next = CTRL_ACTIVE_READ;
            end
          end
        end
        CTRL_STOP: begin
          phy_op = OP_STOP;
          state_next = CTRL_IDLE;
        end
        default: begin
          state_next = CTRL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CTRL_IDLE;
      cmd_ready <= 1'b0;
      data_in_ready <= 1'b0;
      data_out_valid <= 1'b0;
      missed_ack <= 1'b0;
      busy <= 1'b0;
    end else begin
      state <= state_next;
      cmd_ready <= cmd_ready_next;
      data_in_ready <= data_in_ready_next;
      data_out_valid <= data_out_valid_next;
      missed_ack <= missed_ack_next;
      // busy outside the resting states of either FSM
      busy <= !(state == CTRL_IDLE || state == CTRL_ACTIVE_WRITE ||
                state == CTRL_ACTIVE_READ) || phy_busy;
    end
  end

  always_ff @(posedge clk) begin
    addr_reg <= addr_next;
    data_reg <= data_next;
    data_out <= data_out_next;
    bit_count <= bit_count_next;
    mode_read <= mode_read_next;
    mode_stop <= mode_stop_next;
  end

endmodule

`default_nettype wire

//--- source/i2c_master.sv
/*
  I2C master top level, single-byte commands with valid/ready handshakes.
  scl_o/sda_o are open-drain levels (1 = released). Do not loop them
  straight back to scl_i/sda_i, or clock stretching cannot be seen.
*/
`default_nettype none

module i2c_master import i2c_types_pkg::*, i2c_fsm_pkg::*; #(
  // quarter SCL period in clk cycles
  parameter logic [PRESCALE_W-1:0] PRESCALE = 16'd4
) (
  input  logic      clk,
  input  logic      rst,
  input  i2c_addr_t cmd_address,
  input  logic      cmd_start,
  input  logic      cmd_read,
  input  logic      cmd_write,
  input  logic      cmd_stop,
  input  logic      cmd_valid,
  output logic      cmd_ready,
  input  i2c_byte_t data_in,
  input  logic      data_in_valid,
  output logic      data_in_ready,
  output i2c_byte_t data_out,
  output logic      data_out_valid,
  input  logic      data_out_ready,
  input  logic      scl_i,
  output logic      scl_o,
  input  logic      sda_i,
  output logic      sda_o,
  output logic      busy,
  output logic      bus_control,
  output logic      bus_active,
  output logic      missed_ack
);

  logic    scl_sync;
  logic    sda_sync;
  phy_op_t phy_op;
  logic    phy_tx_bit;
  logic    phy_busy;
  logic    phy_rx_bit;

  i2c_bus_monitor u_bus_monitor (
    .clk        (clk),
    .rst        (rst),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_sync   (scl_sync),
    .sda_sync   (sda_sync),
    .bus_active (bus_active)
  );

  i2c_bit_phy #(
    .PRESCALE (PRESCALE)
  ) u_bit_phy (
    .clk         (clk),
    .rst         (rst),
    .phy_op      (phy_op),
    .phy_tx_bit  (phy_tx_bit),
    .scl_sync    (scl_sync),
    .sda_sync    (sda_sync),
    .phy_busy    (phy_busy),
    .phy_rx_bit  (phy_rx_bit),
    .scl_o       (scl_o),
    .sda_o       (sda_o),
    .bus_control (bus_control)
  );

  i2c_byte_ctrl u_byte_ctrl (
    .clk            (clk),
    .rst            (rst),
    .cmd_address    (cmd_address),
    .cmd_start      (cmd_start),
    .cmd_read       (cmd_read),
    .cmd_write      (cmd_write),
    .cmd_stop       (cmd_stop),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready),
    .bus_active     (bus_active),
    .phy_busy       (phy_busy),
    .phy_rx_bit     (phy_rx_bit),
    .phy_op         (phy_op),
    .phy_tx_bit     (phy_tx_bit),
    .busy           (busy),
    .missed_ack     (missed_ack)
  );

endmodule

`default_nettype wire

//--- verif/i2c_target_model.sv
/*
  Behavioral I2C target with one data register, 7-bit address only.
  Samples the bus on clk, holds SCL low for a while after each of its
  own ACKs, ignores other addresses.
*/
`default_nettype none

module i2c_target_model #(
  parameter logic [6:0] ADDR = 7'h2a
) (
  input  logic clk,
  input  logic rst,
  input  logic scl,
  input  logic sda,
  output logic scl_release,
  output logic sda_drive
);

  typedef enum logic [1:0] {T_IDLE, T_ADDR, T_WRITE, T_READ} target_state_t;

  target_state_t state;
  logic       scl_q;
  logic       sda_q;
  logic [7:0] shift;
  logic [7:0] data_reg;
  // rising scl edges seen in this byte, 9 after the ack slot
  logic [3:0] cnt;
  logic       read_mode;
  logic       master_ack;
  // scl held low while nonzero, counts down each clk
  logic [3:0] stretch;

  assign scl_release = (stretch == 4'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T_IDLE;
      scl_q <= 1'b1;
      sda_q <= 1'b1;
      shift <= 8'h00;
      data_reg <= 8'h00;
      cnt <= 4'd0;
      read_mode <= 1'b0;
      master_ack <= 1'b0;
      sda_drive <= 1'b1;
      stretch <= 4'd0;
    end else begin
      scl_q <= scl;
      sda_q <= sda;
      if (stretch != 4'd0) begin
        stretch <= stretch - 4'd1;
      end
      if (scl && scl_q && sda_q && !sda) begin
        // start or repeated start
        state <= T_ADDR;
        cnt <= 4'd0;
        sda_drive <= 1'b1;
      end else if (scl && scl_q && !sda_q && sda) begin
        state <= T_IDLE;
        sda_drive <= 1'b1;
      end else if (scl && !scl_q && state != T_IDLE) begin
        if (state != T_READ && cnt < 4'd8) begin
          shift <= {shift[6:0], sda};
        end
        if (state == T_READ && cnt == 4'd8) begin
          // low sda in the ack slot means the master wants more
          master_ack <= !sda;
        end
        cnt <= cnt + 4'd1;
      end else if (!scl && scl_q) begin
        case (state)
          T_ADDR: begin
            if (cnt == 4'd8) begin
              if (shift[7:1] == ADDR) begin
                sda_drive <= 1'b0;
                read_mode <= shift[0];
                stretch <= 4'd15;
              end else begin
                state <= T_IDLE;
              end
            end else if (cnt == 4'd9) begin
              cnt <= 4'd0;
              if (read_mode) begin
                state <= T_READ;
                sda_drive <= data_reg[7];
              end else begin
                state <= T_WRITE;
                sda_drive <= 1'b1;
              end
            end
          end
          T_WRITE: begin
            if (cnt == 4'd8) begin
              data_reg <= shift;
              sda_drive <= 1'b0;
              stretch <= 4'd15;
            end else if (cnt == 4'd9) begin
              sda_drive <= 1'b1;
              cnt <= 4'd0;
            end
          end
          T_READ: begin
            if (cnt > 4'd0 && cnt < 4'd8) begin
              sda_drive <= data_reg[3'(4'd7 - cnt)];
            end else if (cnt == 4'd8) begin
              sda_drive <= 1'b1;
            end else if (cnt == 4'd9) begin
              if (master_ack) begin
                cnt <= 4'd0;
                sda_drive <= data_reg[7];
              end else begin
                state <= T_IDLE;
                sda_drive <= 1'b1;
              end
            end
          end
          default: begin
            sda_drive <= 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/i2c_master_asserts.sv
/*
  Protocol checks on the byte controller, bound into every instance.
*/
`default_nettype none

module i2c_master_asserts import i2c_fsm_pkg::*; (
  input logic       clk,
  input logic       rst,
  input phy_op_t    phy_op,
  input logic       phy_busy,
  input logic       missed_ack,
  input logic [7:0] data_out,
  input logic       data_out_valid,
  input logic       data_out_ready
);

  // requests only go to an idle phy, which then picks them up
  op_while_free: assert property (@(posedge clk) disable iff (rst)
    (phy_op != OP_NONE) |-> !phy_busy ##1 phy_busy)
    else $error("phy request while busy or not taken by the phy");

  // one cycle pulse per ack slot
  ack_pulse: assert property (@(posedge clk) disable iff (rst)
    missed_ack |=> !missed_ack)
    else $error("missed_ack held for two cycles");

  // read data held unchanged until the host takes it
  out_hold: assert property (@(posedge clk) disable iff (rst)
    (data_out_valid && !data_out_ready) |=> (data_out_valid && $stable(data_out)))
    else $error("read data dropped or changed without data_out_ready");

endmodule

bind i2c_byte_ctrl i2c_master_asserts u_asserts (
  .clk            (clk),
  .rst            (rst),
  .phy_op         (phy_op),
  .phy_busy       (phy_busy),
  .missed_ack     (missed_ack),
  .data_out       (data_out),
  .data_out_valid (data_out_valid),
  .data_out_ready (data_out_ready)
);

`default_nettype wire

//--- verif/tb_i2c_master.sv
/*
  Testbench for the I2C master against one target at 7'h2a.
  Random data and stalls from a fixed seed; the first failure ends the run.
*/
`default_nettype none

module tb_i2c_master import i2c_types_pkg::*; ();

  localparam i2c_addr_t TARGET_ADDR = 7'h2a;
  localparam int LIMIT = 4000;

  logic clk;
  logic rst;
  i2c_addr_t cmd_address;
  logic cmd_start;
  logic cmd_read;
  logic cmd_write;
  logic cmd_stop;
  logic cmd_valid;
  logic cmd_ready;
  i2c_byte_t data_in;
  logic data_in_valid;
  logic data_in_ready;
  i2c_byte_t data_out;
  logic data_out_valid;
  logic data_out_ready;
  logic scl_i;
  logic scl_o;
  logic sda_i;
  logic sda_o;
  logic busy;
  logic bus_control;
  logic bus_active;
  logic missed_ack;
  logic scl_release;
  logic sda_drive;

  // reference copy of the target register
  i2c_byte_t model_byte;
  i2c_byte_t got;
  i2c_addr_t bad_addr;
  int miss_count;
  int miss_base;

  // open-drain wired AND
  assign scl_i = scl_o & scl_release;
  assign sda_i = sda_o & sda_drive;

  i2c_master #(.PRESCALE(16'd4)) dut (.*);

  i2c_target_model #(.ADDR(TARGET_ADDR)) u_target (
    .clk         (clk),
    .rst         (rst),
    .scl         (scl_i),
    .sda         (sda_i),
    .scl_release (scl_release),
    .sda_drive   (sda_drive)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      miss_count <= 0;
    end else if (missed_ack) begin
      miss_count <= miss_count + 1;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
    assert (act == exp)
      else fail_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act == exp)
      else fail_run($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    assert (act == exp)
      else fail_run($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
  endtask

  task automatic send_cmd(input i2c_addr_t addr, input logic rd, input logic wr,
                          input logic stp);
    int n;
    n = 0;
    cmd_address <= addr;
    cmd_read <= rd;
    cmd_write <= wr;
    cmd_stop <= stp;
    cmd_start <= 1'b0;
    cmd_valid <= 1'b1;
    @(posedge clk);
    while (!cmd_ready) begin
      n++;
      if (n > LIMIT) fail_run("command was never accepted");
      @(posedge clk);
    end
    cmd_valid <= 1'b0;
  endtask

  task automatic send_data(input i2c_byte_t d);
    int n;
    n = 0;
    data_in <= d;
    data_in_valid <= 1'b1;
    @(posedge clk);
    while (!data_in_ready) begin
      n++;
      if (n > LIMIT) fail_run("write data was never taken");
      @(posedge clk);
    end
    data_in_valid <= 1'b0;
  endtask

  // busy rises after a command and falls when it is done
  task automatic wait_done();
    int n;
    n = 0;
    while (!busy) begin
      n++;
      if (n > LIMIT) fail_run("busy never went high");
      @(posedge clk);
    end
    n = 0;
    while (busy) begin
      n++;
      if (n > LIMIT) fail_run("busy never went low");
      @(posedge clk);
    end
  endtask

  task automatic take_byte(input logic keep_active, output i2c_byte_t d);
    int n;
    n = 0;
    forever begin
      data_out_ready <= ($urandom_range(3) == 0);
      @(posedge clk);
      if (keep_active) check_bit("bus_active while stalled", 1'b1, bus_active);
      if (data_out_valid && data_out_ready) break;
      n++;
      if (n > LIMIT) fail_run("read data never arrived");
    end
    d = data_out;
    data_out_ready <= 1'b0;
  endtask

  task automatic wait_bus_idle();
    int n;
    n = 0;
    while (bus_active) begin
      n++;
      if (n > 20) fail_run("bus_active stayed high after stop");
      @(posedge clk);
    end
  endtask

  task automatic write_byte(input i2c_addr_t addr, input i2c_byte_t d, input logic stp);
    send_cmd(addr, 1'b0, 1'b1, stp);
    send_data(d);
    wait_done();
  endtask

  task automatic read_byte(input logic stp, input logic keep_active, output i2c_byte_t d);
    send_cmd(TARGET_ADDR, 1'b1, 1'b0, stp);
    wait_done();
    take_byte(keep_active, d);
  endtask

  initial begin
    void'($urandom(32'hd4c3));
    rst = 1'b1;
    cmd_address = '0;
    cmd_start = 1'b0;
    cmd_read = 1'b0;
    cmd_write = 1'b0;
    cmd_stop = 1'b0;
    cmd_valid = 1'b0;
    data_in = '0;
    data_in_valid = 1'b0;
    data_out_ready = 1'b0;
    model_byte = 8'h00;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // values still from reset at this edge
    check_bit("reset cmd_ready", 1'b0, cmd_ready);
    check_bit("reset data_in_ready", 1'b0, data_in_ready);
    check_bit("reset data_out_valid", 1'b0, data_out_valid);
    check_bit("reset missed_ack", 1'b0, missed_ack);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset bus_active", 1'b0, bus_active);
    check_bit("reset bus_control", 1'b0, bus_control);
    check_bit("reset scl_o", 1'b1, scl_o);
    check_bit("reset sda_o", 1'b1, sda_o);

    // write then read back
    miss_base = miss_count;
    model_byte = i2c_byte_t'($urandom);
    write_byte(TARGET_ADDR, model_byte, 1'b1);
    check_bit("bus_control after write with stop", 1'b0, bus_control);
    wait_bus_idle();
    read_byte(1'b1, 1'b0, got);
    check_byte("write then read", model_byte, got);
    repeat (4) @(posedge clk);
    check_int("write then read missed_ack", 0, miss_count - miss_base);
    wait_bus_idle();

    // chained reads on one transaction
    for (int i = 0; i < 4; i++) begin
      read_byte(1'b0, 1'b1, got);
      check_byte("consecutive read", model_byte, got);
      check_bit("bus_active between reads", 1'b1, bus_active);
    end
    read_byte(1'b1, 1'b0, got);
    check_byte("final read", model_byte, got);
    wait_bus_idle();

    // nobody answers a wrong address
    miss_base = miss_count;
    bad_addr = i2c_addr_t'($urandom);
    while (bad_addr == TARGET_ADDR) bad_addr = i2c_addr_t'($urandom);
    write_byte(bad_addr, i2c_byte_t'($urandom), 1'b1);
    repeat (4) @(posedge clk);
    check_int("wrong address missed_ack", 2, miss_count - miss_base);
    wait_bus_idle();
    read_byte(1'b1, 1'b0, got);
    check_byte("after wrong address", model_byte, got);
    wait_bus_idle();

    // open write closed by a stop command
    model_byte = i2c_byte_t'($urandom);
    write_byte(TARGET_ADDR, model_byte, 1'b0);
    check_bit("bus_active after open write", 1'b1, bus_active);
    check_bit("bus_control after open write", 1'b1, bus_control);
    send_cmd(TARGET_ADDR, 1'b0, 1'b0, 1'b1);
    wait_done();
    // stop condition is seen on the bus before busy drops
    check_bit("bus_active after stop command", 1'b0, bus_active);
    check_bit("bus_control after stop command", 1'b0, bus_control);
    read_byte(1'b1, 1'b0, got);
    check_byte("read after stop command", model_byte, got);
    wait_bus_idle();

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
source/i2c_types_pkg.sv
source/i2c_fsm_pkg.sv
source/i2c_bus_monitor.sv
source/i2c_bit_phy.sv
source/i2c_byte_ctrl.sv
source/i2c_master.sv
verif/i2c_target_model.sv
verif/i2c_master_asserts.sv
verif/tb_i2c_master.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the I2C master testbench with Verilator.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_i2c_master \
  -o sim_tb_i2c_master
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit $status
fi

./obj_dir/sim_tb_i2c_master
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi
exit 0
